// File: common/rename_macros.svh
// Rename stage sizing macros

`ifndef RENAME_MACROS_SVH
`define RENAME_MACROS_SVH

// Architectural register file
`define RN_ARCH_REGS 32
`define RN_ARCH_W 5

// Physical tag space
`define RN_PHYS_TAGS 64
`define RN_TAG_W 6

// Tags free after reset, the upper half of the tag space
`define RN_FREE_TAGS 32

`endif

// File: common/rename_pkg.sv
// Rename stage types

`include "rename_macros.svh"

package rename_pkg;

  typedef enum logic [2:0] {
    UNKNOWN,
    ALU,
    LOAD,
    STORE,
    JUMP
  } instr_class_t;

  typedef struct packed {
    logic writes;
    logic jumps;
    // Speculative, set behind an unresolved jump
    logic tag;
    logic spare;
  } instr_flags_t;

  typedef struct packed {
    logic [31:0] address;
    logic [31:0] immediate;
    instr_class_t instr_class;
    logic [`RN_ARCH_W-1:0] rs_1;
    logic [`RN_ARCH_W-1:0] rs_2;
    logic [`RN_ARCH_W-1:0] rd;
    instr_flags_t flags;
  } instr_in_t;

  typedef struct packed {
    logic [`RN_TAG_W-1:0] rs_1;
    logic [`RN_TAG_W-1:0] rs_2;
    logic [`RN_TAG_W-1:0] rn;
  } src_tags_t;

  typedef struct packed {
    logic [31:0] address;
    logic [31:0] immediate;
    instr_class_t instr_class;
    logic [`RN_ARCH_W-1:0] rd;
    logic [`RN_TAG_W-1:0] rs_1;
    logic [`RN_TAG_W-1:0] rs_2;
    logic [`RN_TAG_W-1:0] rn;
    instr_flags_t flags;
  } instr_out_t;

  // One map table update request
  typedef struct packed {
    logic en;
    logic [`RN_ARCH_W-1:0] rd;
    logic [`RN_TAG_W-1:0] tag;
  } map_write_t;

  typedef instr_in_t [1:0] pair_in_t;
  typedef instr_out_t [1:0] pair_out_t;

endpackage

// File: rename/rename_map_table.sv
// Register alias table

`timescale 1ns/1ps
`include "rename_macros.svh"

module rename_map_table (
  input  logic                           i_clock,
  input  logic                           i_reset,
  input  rename_pkg::pair_in_t           i_pair,
  output rename_pkg::src_tags_t [1:0]    o_src_tags,
  input  rename_pkg::map_write_t [1:0]   i_map_write
);

  // Current physical tag of each architectural register
  logic [`RN_TAG_W-1:0] map_q [`RN_ARCH_REGS];

  // Register 0 is hardwired to tag 0
  function automatic logic [`RN_TAG_W-1:0] lookup(input logic [`RN_ARCH_W-1:0] arch);
    logic [`RN_TAG_W-1:0] tag;
    if (arch == '0) begin
      tag = '0;
    end else begin
      tag = map_q[arch];
    end
    return tag;
  endfunction

  // Four source read ports, two per slot
  always_comb begin
    for (int s = 0; s < 2; s++) begin
      o_src_tags[s].rs_1 = lookup(i_pair[s].rs_1);
      o_src_tags[s].rs_2 = lookup(i_pair[s].rs_2);
      // Allocation is done by the resolver
      o_src_tags[s].rn = '0;
    end
  end

  // Identity map on reset, slot 1 writes last so it wins a collision
  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      for (int r = 0; r < `RN_ARCH_REGS; r++) begin
        map_q[r] <= `RN_TAG_W'(r);
      end
    end else begin
      for (int s = 0; s < 2; s++) begin
        if (i_map_write[s].en) begin
          map_q[i_map_write[s].rd] <= i_map_write[s].tag;
        end
      end
    end
  end

  // The resolver must never remap the zero register
  a_no_zero_write_0 : assert property (
    @(posedge i_clock) disable iff (i_reset)
    !(i_map_write[0].en && i_map_write[0].rd == '0)
  );

  a_no_zero_write_1 : assert property (
    @(posedge i_clock) disable iff (i_reset)
    !(i_map_write[1].en && i_map_write[1].rd == '0)
  );

endmodule

// File: rename/free_tag_list.sv
// Free physical tag FIFO

`timescale 1ns/1ps
`include "rename_macros.svh"

module free_tag_list (
  input  logic                       i_clock,
  input  logic                       i_reset,
  output logic [1:0][`RN_TAG_W-1:0]  o_head_tags,
  output logic [`RN_TAG_W:0]         o_free_count,
  input  logic [1:0]                 i_alloc_count,
  input  logic                       i_release_valid,
  input  logic [`RN_TAG_W-1:0]       i_release_tag
);

  localparam int FIRST_FREE = `RN_PHYS_TAGS - `RN_FREE_TAGS;

  logic [`RN_TAG_W-1:0] fifo_q [`RN_PHYS_TAGS];
  // Pointers wrap naturally at the buffer depth
  logic [`RN_TAG_W-1:0] rd_ptr_q;
  logic [`RN_TAG_W-1:0] wr_ptr_q;
  logic [`RN_TAG_W:0]   count_q;
  logic [`RN_TAG_W:0]   count_next;
  logic [`RN_TAG_W-1:0] rd_ptr_plus1;

  assign rd_ptr_plus1 = rd_ptr_q + `RN_TAG_W'(1);

  // Two oldest free tags, only valid up to the count
  assign o_head_tags[0] = fifo_q[rd_ptr_q];
  assign o_head_tags[1] = fifo_q[rd_ptr_plus1];
  assign o_free_count   = count_q;

  always_comb begin
    count_next = count_q - {{(`RN_TAG_W-1){1'b0}}, i_alloc_count};
    if (i_release_valid) begin
      count_next = count_next + {{`RN_TAG_W{1'b0}}, 1'b1};
    end
  end

  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      // Preload the upper tags in ascending order
      for (int i = 0; i < `RN_FREE_TAGS; i++) begin
        fifo_q[i] <= `RN_TAG_W'(FIRST_FREE + i);
      end
      rd_ptr_q <= '0;
      wr_ptr_q <= `RN_TAG_W'(`RN_FREE_TAGS);
      count_q  <= (`RN_TAG_W+1)'(`RN_FREE_TAGS);
    end else begin
      rd_ptr_q <= rd_ptr_q + `RN_TAG_W'(i_alloc_count);
      if (i_release_valid) begin
        fifo_q[wr_ptr_q] <= i_release_tag;
        wr_ptr_q         <= wr_ptr_q + `RN_TAG_W'(1);
      end
      count_q <= count_next;
    end
  end

  // Resolver may only take tags that are present
  a_pop_within_count : assert property (
    @(posedge i_clock) disable iff (i_reset)
    {{(`RN_TAG_W-1){1'b0}}, i_alloc_count} <= count_q
  );

  // A double release would overfill the buffer
  a_count_bounded : assert property (
    @(posedge i_clock) disable iff (i_reset)
    count_q <= (`RN_TAG_W+1)'(`RN_PHYS_TAGS)
  );

endmodule

// File: rename/pair_resolver.sv
// Rename pair resolver

`timescale 1ns/1ps
`include "rename_macros.svh"

module pair_resolver (
  input  logic                          i_clock,
  input  logic                          i_reset,
  input  rename_pkg::pair_in_t          i_pair,
  input  logic                          i_pair_valid,
  output logic                          o_pair_ready,
  input  logic                          i_speculative,
  input  rename_pkg::src_tags_t [1:0]   i_src_tags,
  input  logic [1:0][`RN_TAG_W-1:0]     i_head_tags,
  input  logic [`RN_TAG_W:0]            i_free_count,
  output logic [1:0]                    o_alloc_count,
  output rename_pkg::map_write_t [1:0]  o_map_write,
  output rename_pkg::pair_out_t         o_renamed,
  output logic                          o_renamed_valid,
  input  logic                          i_renamed_ready,
  output logic                          o_panic
);

  logic [1:0]                need;
  logic [1:0]                need_count;
  logic [`RN_TAG_W:0]        need_wide;
  logic [1:0][`RN_TAG_W-1:0] rn_tag;
  logic                      out_free;
  logic                      accept;
  rename_pkg::pair_out_t     renamed_next;

  // True when the second slot reads what the first slot produces
  function automatic logic depends(input rename_pkg::instr_in_t older,
                                   input logic [`RN_ARCH_W-1:0] rs);
    return older.flags.writes && older.rd != '0 && older.rd == rs;
  endfunction

  // Decode must split pairs with two jumps
  assign o_panic = i_pair_valid && i_pair[0].flags.jumps && i_pair[1].flags.jumps;

  assign need[0]    = i_pair[0].flags.writes && i_pair[0].rd != '0;
  assign need[1]    = i_pair[1].flags.writes && i_pair[1].rd != '0;
  assign need_count = {1'b0, need[0]} + {1'b0, need[1]};
  assign need_wide  = {{(`RN_TAG_W-1){1'b0}}, need_count};

  assign out_free     = !o_renamed_valid || i_renamed_ready;
  assign o_pair_ready = out_free && (i_free_count >= need_wide) && !o_panic;
  assign accept       = i_pair_valid && o_pair_ready;

  // Slot 1 takes the next tag in FIFO order after slot 0
  assign rn_tag[0] = need[0] ? i_head_tags[0] : '0;
  assign rn_tag[1] = need[1] ? (need[0] ? i_head_tags[1] : i_head_tags[0]) : '0;

  assign o_alloc_count = accept ? need_count : 2'd0;

  always_comb begin
    for (int s = 0; s < 2; s++) begin
      o_map_write[s].en  = accept && need[s];
      o_map_write[s].rd  = i_pair[s].rd;
      o_map_write[s].tag = rn_tag[s];
    end
  end

  always_comb begin
    for (int s = 0; s < 2; s++) begin
      renamed_next[s].address     = i_pair[s].address;
      renamed_next[s].immediate   = i_pair[s].immediate;
      renamed_next[s].instr_class = i_pair[s].instr_class;
      renamed_next[s].rd          = i_pair[s].rd;
      renamed_next[s].rs_1        = i_src_tags[s].rs_1;
      renamed_next[s].rs_2        = i_src_tags[s].rs_2;
      renamed_next[s].rn          = rn_tag[s];
      renamed_next[s].flags       = i_pair[s].flags;
      renamed_next[s].flags.tag   = i_pair[s].flags.jumps ? 1'b0 : i_speculative;
    end
    // Intra-pair bypass, the table does not yet hold slot 0's mapping
    if (depends(i_pair[0], i_pair[1].rs_1)) begin
      renamed_next[1].rs_1 = rn_tag[0];
    end
    if (depends(i_pair[0], i_pair[1].rs_2)) begin
      renamed_next[1].rs_2 = rn_tag[0];
    end
    // Everything behind a jump is speculative
    if (!i_pair[1].flags.jumps && i_pair[0].flags.jumps) begin
      renamed_next[1].flags.tag = 1'b1;
    end
  end

  always_ff @(posedge i_clock) begin
    if (accept) begin
      o_renamed <= renamed_next;
    end
  end

  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      o_renamed_valid <= 1'b0;
    end else if (accept) begin
      o_renamed_valid <= 1'b1;
    end else if (i_renamed_ready) begin
      o_renamed_valid <= 1'b0;
    end
  end

  // Stalled output holds its pair until dispatch takes it
  a_stall_stable : assert property (
    @(posedge i_clock) disable iff (i_reset)
    o_renamed_valid && !i_renamed_ready |=> o_renamed_valid && $stable(o_renamed)
  );

endmodule

// File: verilog/rename_stage.sv
// Rename stage top level

`timescale 1ns/1ps
`include "rename_macros.svh"

module rename_stage (
  input  logic                   i_clock,
  input  logic                   i_reset,
  input  rename_pkg::pair_in_t   i_pair,
  input  logic                   i_pair_valid,
  output logic                   o_pair_ready,
  input  logic                   i_speculative,
  output rename_pkg::pair_out_t  o_renamed,
  output logic                   o_renamed_valid,
  input  logic                   i_renamed_ready,
  input  logic                   i_release_valid,
  input  logic [`RN_TAG_W-1:0]   i_release_tag,
  output logic                   o_panic
);

  rename_pkg::src_tags_t [1:0]  src_tags;
  rename_pkg::map_write_t [1:0] map_write;
  logic [1:0][`RN_TAG_W-1:0]    head_tags;
  logic [`RN_TAG_W:0]           free_count;
  logic [1:0]                   alloc_count;

  rename_map_table u_map_table (
    .i_clock     (i_clock),
    .i_reset     (i_reset),
    .i_pair      (i_pair),
    .o_src_tags  (src_tags),
    .i_map_write (map_write)
  );

  free_tag_list u_free_list (
    .i_clock         (i_clock),
    .i_reset         (i_reset),
    .o_head_tags     (head_tags),
    .o_free_count    (free_count),
    .i_alloc_count   (alloc_count),
    .i_release_valid (i_release_valid),
    .i_release_tag   (i_release_tag)
  );

  pair_resolver u_resolver (
    .i_clock         (i_clock),
    .i_reset         (i_reset),
    .i_pair          (i_pair),
    .i_pair_valid    (i_pair_valid),
    .o_pair_ready    (o_pair_ready),
    .i_speculative   (i_speculative),
    .i_src_tags      (src_tags),
    .i_head_tags     (head_tags),
    .i_free_count    (free_count),
    .o_alloc_count   (alloc_count),
    .o_map_write     (map_write),
    .o_renamed       (o_renamed),
    .o_renamed_valid (o_renamed_valid),
    .i_renamed_ready (i_renamed_ready),
    .o_panic         (o_panic)
  );

endmodule

// File: verif/tb_clock_gen.sv
// Testbench clock and reset

`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 3
) (
  output logic o_clock,
  output logic o_reset
);

  initial begin
    o_clock = 1'b0;
    forever begin
      #(PERIOD_NS / 2) o_clock = ~o_clock;
    end
  end

  // Reset covers the first rising edges and drops on a falling edge
  initial begin
    o_reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge o_clock);
    @(negedge o_clock);
    o_reset = 1'b0;
  end

endmodule

// File: verif/rename_stage_tb.sv
// Rename stage testbench

`timescale 1ns/1ps
`include "rename_macros.svh"

module rename_stage_tb;

  localparam int CLOCK_NS        = 8;
  localparam int CYCLES_PER_LINE = 40;

  logic                  clock;
  logic                  reset;
  rename_pkg::pair_in_t  i_pair;
  logic                  i_pair_valid;
  logic                  o_pair_ready;
  logic                  i_speculative;
  rename_pkg::pair_out_t o_renamed;
  logic                  o_renamed_valid;
  logic                  i_renamed_ready;
  logic                  i_release_valid;
  logic [`RN_TAG_W-1:0]  i_release_tag;
  logic                  o_panic;

  // One entry per data line
  string                 kinds[$];
  rename_pkg::pair_in_t  pairs[$];
  logic                  specs[$];
  rename_pkg::pair_out_t expects[$];
  int                    release_tags[$];
  bit                    released[$];
  bit                    loaded;

  // Accepted pairs still to come out of the output register
  rename_pkg::pair_out_t pending[$];
  logic [31:0]           rng_state;
  int                    free_model;

  tb_clock_gen #(.PERIOD_NS(CLOCK_NS), .RESET_CYCLES(3)) u_clock_gen (
    .o_clock (clock),
    .o_reset (reset)
  );

  rename_stage u_rename_stage (
    .i_clock         (clock),
    .i_reset         (reset),
    .i_pair          (i_pair),
    .i_pair_valid    (i_pair_valid),
    .o_pair_ready    (o_pair_ready),
    .i_speculative   (i_speculative),
    .o_renamed       (o_renamed),
    .o_renamed_valid (o_renamed_valid),
    .i_renamed_ready (i_renamed_ready),
    .i_release_valid (i_release_valid),
    .i_release_tag   (i_release_tag),
    .o_panic         (o_panic)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // A slot takes a tag only when it writes a nonzero register
  function automatic int tags_needed(input rename_pkg::pair_in_t pair);
    int n;
    n = 0;
    for (int s = 0; s < 2; s++) begin
      if (pair[s].flags.writes && pair[s].rd != '0) begin
        n++;
      end
    end
    return n;
  endfunction

  // First release line right after a pair that has not been driven yet
  function automatic int next_release(input int from);
    int k;
    int found;
    k = from + 1;
    found = -1;
    while (k < kinds.size() && kinds[k] == "R" && released[k]) begin
      k++;
    end
    if (k < kinds.size() && kinds[k] == "R") begin
      found = k;
    end
    return found;
  endfunction

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("CHECKS FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_pair(input rename_pkg::pair_out_t expected,
                            input rename_pkg::pair_out_t actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("mismatch at %0t: o_renamed expected %h got %h",
                                  $time, expected, actual));
    end
  endtask

  task automatic check_panic(input logic expected, input logic actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("mismatch at %0t: o_panic expected %b got %b",
                                  $time, expected, actual));
    end
  endtask

  task automatic load_tests();
    int fd;
    string kind;
    string rest;
    rename_pkg::pair_in_t pair;
    rename_pkg::pair_out_t expected;
    logic [31:0] addr;
    logic [31:0] imm;
    int cls;
    int rs1;
    int rs2;
    int rd;
    int flg;
    int spec;
    int tag;
    int e_rs1;
    int e_rs2;
    int e_rn;
    int e_tag;
    fd = $fopen("verif/rename_tests.txt", "r");
    if (fd == 0) begin
      stop_with_failure("cannot open verif/rename_tests.txt");
    end
    while ($fscanf(fd, " %s", kind) == 1) begin
      if (kind.substr(0, 0) == "#") begin
        void'($fgets(rest, fd));
        continue;
      end
      pair = '0;
      expected = '0;
      spec = 0;
      tag = 0;
      if (kind == "P" || kind == "X") begin
        for (int s = 0; s < 2; s++) begin
          if ($fscanf(fd, " %h %h %d %d %d %d %h", addr, imm, cls, rs1, rs2, rd, flg) != 7) begin
            stop_with_failure("malformed pair fields in the test file");
          end
          pair[s].address     = addr;
          pair[s].immediate   = imm;
          pair[s].instr_class = rename_pkg::instr_class_t'(cls[2:0]);
          pair[s].rs_1        = rs1[`RN_ARCH_W-1:0];
          pair[s].rs_2        = rs2[`RN_ARCH_W-1:0];
          pair[s].rd          = rd[`RN_ARCH_W-1:0];
          pair[s].flags       = rename_pkg::instr_flags_t'(flg[3:0]);
        end
        if ($fscanf(fd, " %d", spec) != 1) begin
          stop_with_failure("missing speculative bit in the test file");
        end
      end
      if (kind == "P") begin
        // Fields not renamed pass straight through
        for (int s = 0; s < 2; s++) begin
          if ($fscanf(fd, " %d %d %d %d", e_rs1, e_rs2, e_rn, e_tag) != 4) begin
            stop_with_failure("malformed expected result in the test file");
          end
          expected[s].address     = pair[s].address;
          expected[s].immediate   = pair[s].immediate;
          expected[s].instr_class = pair[s].instr_class;
          expected[s].rd          = pair[s].rd;
          expected[s].rs_1        = e_rs1[`RN_TAG_W-1:0];
          expected[s].rs_2        = e_rs2[`RN_TAG_W-1:0];
          expected[s].rn          = e_rn[`RN_TAG_W-1:0];
          expected[s].flags       = pair[s].flags;
          expected[s].flags.tag   = e_tag[0];
        end
      end else if (kind == "R") begin
        if ($fscanf(fd, " %d", tag) != 1) begin
          stop_with_failure("missing release tag in the test file");
        end
      end else if (kind != "X") begin
        stop_with_failure({"unknown line kind in the test file: ", kind});
      end
      kinds.push_back(kind);
      pairs.push_back(pair);
      specs.push_back(spec[0]);
      expects.push_back(expected);
      release_tags.push_back(tag);
      released.push_back(1'b0);
    end
    $fclose(fd);
  endtask

  // Drive on the falling edge, then sample once the inputs have settled
  task automatic drive_cycle(input rename_pkg::pair_in_t pair, input logic valid,
                             input logic spec, input logic rel_valid, input int rel_tag,
                             input logic exp_panic, output logic accepted);
    @(negedge clock);
    rng_state = xorshift32(rng_state);
    i_renamed_ready = rng_state[1:0] != 2'b00;
    i_pair          = pair;
    i_pair_valid    = valid;
    i_speculative   = spec;
    i_release_valid = rel_valid;
    i_release_tag   = rel_tag[`RN_TAG_W-1:0];
    #1;
    check_panic(exp_panic, o_panic);
    accepted = valid && o_pair_ready;
    if (o_renamed_valid && i_renamed_ready) begin
      if (pending.size() == 0) begin
        stop_with_failure("o_renamed_valid rose with no accepted pair outstanding");
      end else begin
        check_pair(pending.pop_front(), o_renamed);
      end
    end
  endtask

  initial begin
    int i;
    int j;
    logic accepted;
    logic enough;
    logic rel_valid;
    i_pair          = '0;
    i_pair_valid    = 1'b0;
    i_speculative   = 1'b0;
    i_renamed_ready = 1'b0;
    i_release_valid = 1'b0;
    i_release_tag   = '0;
    rng_state  = 32'd90;
    free_model = `RN_FREE_TAGS;
    load_tests();
    loaded = 1'b1;
    @(negedge reset);
    i = 0;
    while (i < kinds.size()) begin
      if (kinds[i] == "R") begin
        if (!released[i]) begin
          drive_cycle('0, 1'b0, 1'b0, 1'b1, release_tags[i], 1'b0, accepted);
          released[i] = 1'b1;
          free_model++;
        end
      end else if (kinds[i] == "X") begin
        drive_cycle(pairs[i], 1'b1, specs[i], 1'b0, 0, 1'b1, accepted);
        if (accepted) begin
          stop_with_failure("double-jump pair was accepted");
        end
      end else begin
        accepted = 1'b0;
        while (!accepted) begin
          enough = free_model >= tags_needed(pairs[i]);
          // Hand back the tags of the release lines behind a starved pair
          j = next_release(i);
          rel_valid = !enough && j >= 0;
          drive_cycle(pairs[i], 1'b1, specs[i], rel_valid, rel_valid ? release_tags[j] : 0,
                      1'b0, accepted);
          if (accepted && !enough) begin
            stop_with_failure("pair accepted while the free list was short of tags");
          end
          if (rel_valid) begin
            released[j] = 1'b1;
            free_model++;
          end
        end
        free_model -= tags_needed(pairs[i]);
        pending.push_back(expects[i]);
      end
      i++;
    end
    while (pending.size() != 0) begin
      drive_cycle('0, 1'b0, 1'b0, 1'b0, 0, 1'b0, accepted);
    end
    // A few idle cycles catch any duplicate output
    repeat (4) begin
      drive_cycle('0, 1'b0, 1'b0, 1'b0, 0, 1'b0, accepted);
    end
    $display("ALL CHECKS PASSED");
    $finish;
  end

  initial begin
    wait (loaded);
    repeat (kinds.size() * CYCLES_PER_LINE) @(posedge clock);
    stop_with_failure($sformatf("timeout after %0d cycles without finishing the tests",
                                kinds.size() * CYCLES_PER_LINE));
  end

endmodule

// File: verif/rename_tests.txt
# P: per slot addr imm class rs1 rs2 rd flags (hex w8 j4 t2 s1), spec, per slot rs1 rs2 rn tag
# R: tag released.  X: per slot fields and spec of a double jump.  Class 1 ALU 2 LD 3 ST 4 JMP
P 1000 10 1 1 2 3 8  1004 20 1 4 5 6 8  0  1 2 32 0  4 5 33 0
P 1008 0 1 3 6 7 8  100c 4 1 7 3 8 8  0  32 33 34 0  34 32 35 0
P 1010 0 1 1 2 0 8  1014 7 2 0 3 9 8  0  1 2 0 0  0 32 36 0
P 1018 8 3 7 8 10 0  101c 0 1 10 9 11 8  1  34 35 0 1  10 36 37 1
P 1020 40 4 1 0 1 c  1024 0 1 1 11 12 8  1  1 0 38 0  38 37 39 1
P 1028 0 1 12 0 13 8  102c 80 4 13 0 0 4  1  39 0 40 1  40 0 0 0
P 1030 c 4 5 0 0 4  1034 0 1 13 1 14 9  0  5 0 0 0  40 38 41 1
X 1038 0 4 1 0 0 4  103c 0 4 2 0 2 c  0
P 1040 0 1 14 2 2 8  1044 0 1 2 2 2 8  0  41 2 42 0  42 42 43 0
P 1048 0 1 2 0 15 8  104c 0 1 3 4 16 8  0  43 0 44 0  32 4 45 0
R 3
P 1050 0 1 16 0 17 8  1054 0 1 17 4 18 8  0  45 0 46 0  46 4 47 0
P 1058 0 1 18 0 19 8  105c 0 1 19 5 20 8  0  47 0 48 0  48 5 49 0
P 1060 0 1 20 0 21 8  1064 0 1 21 10 22 8  0  49 0 50 0  50 10 51 0
P 1068 0 1 22 0 23 8  106c 0 1 23 17 24 8  0  51 0 52 0  52 46 53 0
P 1070 0 1 24 0 25 8  1074 0 1 25 18 26 8  0  53 0 54 0  54 47 55 0
P 1078 0 1 26 0 27 8  107c 0 1 27 19 28 8  0  55 0 56 0  56 48 57 0
P 1080 0 1 28 0 29 8  1084 0 1 29 20 30 8  0  57 0 58 0  58 49 59 0
P 1088 0 1 30 0 31 8  108c 0 1 31 21 17 8  0  59 0 60 0  60 50 61 0
P 1090 0 1 17 0 18 8  1094 0 1 18 22 19 8  0  61 0 62 0  62 51 63 0
P 1098 0 1 19 0 20 8  109c 0 3 20 31 0 0  0  63 0 3 0  3 60 0 0
P 10a0 0 1 20 0 21 8  10a4 0 3 21 0 0 0  0  3 0 6 0  6 0 0 0
R 6
P 10a8 0 3 21 20 0 0  10ac 0 2 21 0 0 0  1  6 3 0 1  6 0 0 1

// File: sim.f
+incdir+common
common/rename_pkg.sv
rename/rename_map_table.sv
rename/free_tag_list.sv
rename/pair_resolver.sv
verilog/rename_stage.sv
verif/tb_clock_gen.sv
verif/rename_stage_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the rename stage testbench with Verilator and run it from the project root
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -Wno-fatal \
    --top-module rename_stage_tb -Mdir obj_dir -o rename_sim -f sim.f &&
  ./obj_dir/rename_sim ||
  { echo "rename stage simulation failed" >&2; exit 1; }
